//--- controller.f
controller_pkg.sv
bus_monitor.sv
controller_active.sv
controller_standby.sv
controller.sv
+incdir+.
tb_controller.sv

//--- run.sh
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f controller.f --top-module tb_controller

./obj_dir/Vtb_controller > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
grep -q "PASS: all tests" sim.log

//--- tb_controller_tasks.svh
// Tasks for the controller testbench, included in the module body
// Bus master and target emulation, value checks and test sequences
`ifndef TB_CONTROLLER_TASKS_SVH
`define TB_CONTROLLER_TASKS_SVH

string test_name;
int    test_err0;

function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

task automatic expect_eq(input string what, input logic [31:0] act, input logic [31:0] exp);
    assert (exp === act)
    else begin
        errors++;
        $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
    end
endtask

task automatic begin_test(input string name);
    test_name = name;
    test_err0 = errors;
endtask

task automatic end_test();
    tests_run++;
    if (errors != test_err0) tests_failed++;
    $display("test %s: %s", test_name, (errors == test_err0) ? "ok" : "failed");
endtask

task automatic wait_clk(input int n);
    repeat (n) @(posedge clk_i);
endtask

// Host side of the command queue
task automatic issue_cmd(input cmd_t c);
    @(posedge clk_i);
    cmd_rvalid_i <= 1'b1;
    cmd_rdata_i  <= c;
    do @(posedge clk_i); while (!cmd_rready_o);
    cmd_rvalid_i <= 1'b0;
endtask

task automatic wait_resp();
    while (!resp_wvalid_o) @(posedge clk_i);
endtask

// Target emulation, bits taken at SCL rises
task automatic recv_byte(output logic [7:0] b);
    b = '0;
    repeat (8) begin
        @(posedge scl_i);
        b = {b[6:0], sda_i};
    end
endtask

task automatic ack_slot(input bit drive);
    @(negedge scl_i);
    @(posedge clk_i);
    if (drive) tb_sda <= 1'b0;
    @(posedge scl_i);
    @(negedge scl_i);
    @(posedge clk_i);
    tb_sda <= 1'b1;
endtask

task automatic target_recv(input bit ack, output logic [7:0] ab, output logic [7:0] db);
    db = '0;
    recv_byte(ab);
    ack_slot(ack);
    if (ack) begin
        recv_byte(db);
        ack_slot(1'b1);
    end
endtask

// Master emulation for the standby controller
task automatic send_start();
    tb_sda <= 1'b0;
    wait_clk(2 * TbQuarter);
    tb_scl <= 1'b0;
    wait_clk(TbQuarter);
endtask

task automatic send_stop();
    tb_sda <= 1'b0;
    wait_clk(TbQuarter);
    tb_scl <= 1'b1;
    wait_clk(TbQuarter);
    tb_sda <= 1'b1;
    wait_clk(2 * TbQuarter);
endtask

// Returns the SDA level seen in the ACK slot
task automatic send_byte(input logic [7:0] b, output logic nack);
    for (int i = 7; i >= 0; i--) begin
        tb_sda <= b[i];
        wait_clk(TbQuarter);
        tb_scl <= 1'b1;
        wait_clk(2 * TbQuarter);
        tb_scl <= 1'b0;
    end
    tb_sda <= 1'b1;
    wait_clk(TbQuarter);
    tb_scl <= 1'b1;
    wait_clk(TbQuarter);
    nack = sda_i;
    wait_clk(TbQuarter);
    tb_scl <= 1'b0;
    wait_clk(TbQuarter);
endtask

task automatic run_reset_state();
    begin_test("reset_state");
    @(posedge clk_i);
    expect_eq("cmd_rready", 32'(cmd_rready_o), 32'd0);
    expect_eq("resp_wvalid", 32'(resp_wvalid_o), 32'd0);
    expect_eq("rx_wvalid", 32'(rx_wvalid_o), 32'd0);
    expect_eq("rx_wflush", 32'(rx_wflush_o), 32'd0);
    expect_eq("strobes", 32'({bus_start_o, bus_stop_o, bus_addr_valid_o}), 32'd0);
    expect_eq("pads", 32'({scl_o, sda_o, sel_od_pp_o}), 32'b110);
    expect_eq("idle", 32'(idle_o), 32'd1);
    end_test();
endtask

task automatic run_active_ack();
    cmd_t       c;
    logic [7:0] ab;
    logic [7:0] db;
    int         r0;
    begin_test("active_write_ack");
    c.dev_addr = 7'(lcg_next() >> 9);
    c.data = 8'(lcg_next() >> 16);
    r0 = scl_rises;
    fork
        issue_cmd(c);
        target_recv(1'b1, ab, db);
    join
    wait_resp();
    expect_eq("addr_byte", 32'(ab), 32'({c.dev_addr, 1'b0}));
    expect_eq("data_byte", 32'(db), 32'(c.data));
    expect_eq("resp", 32'(resp_wdata_o), 32'({c.dev_addr, 2'b00}));
    expect_eq("scl_pulses", 32'(scl_rises - r0), 32'd19);
    end_test();
endtask

task automatic run_active_nack();
    cmd_t       c;
    logic [7:0] ab;
    logic [7:0] db;
    int         r0;
    begin_test("active_addr_nack");
    c.dev_addr = 7'(lcg_next() >> 9);
    c.data = 8'(lcg_next() >> 16);
    resp_wready_i <= 1'b0;
    r0 = scl_rises;
    fork
        issue_cmd(c);
        target_recv(1'b0, ab, db);
    join
    wait_resp();
    expect_eq("addr_byte", 32'(ab), 32'({c.dev_addr, 1'b0}));
    expect_eq("resp", 32'(resp_wdata_o), 32'({c.dev_addr, 2'b10}));
    // Address, ACK slot and the STOP rise only
    expect_eq("scl_pulses", 32'(scl_rises - r0), 32'd10);
    held_resp    <= '{dev_addr: c.dev_addr, addr_nack: 1'b1, data_nack: 1'b0};
    hold_chk     <= 1'b1;
    cmd_rvalid_i <= 1'b1;
    cmd_rdata_i  <= ~c;
    wait_clk(20);
    resp_wready_i <= 1'b1;
    cmd_rvalid_i  <= 1'b0;
    hold_chk      <= 1'b0;
    wait_clk(2);
    expect_eq("idle", 32'(idle_o), 32'd1);
    end_test();
endtask

task automatic run_standby_rx();
    logic [7:0] d0;
    logic [7:0] d1;
    logic       nack;
    int         s0;
    int         p0;
    int         a0;
    int         x0;
    int         f0;
    begin_test("standby_receive");
    role_i <= 1'b1;
    d0 = 8'(lcg_next() >> 16);
    d1 = 8'(lcg_next() >> 16);
    s0 = n_start;
    p0 = n_stop;
    a0 = n_addr;
    x0 = n_rx;
    f0 = n_flush;
    wait_clk(2);
    send_start();
    send_byte({own_addr_i, 1'b0}, nack);
    expect_eq("addr_ack", 32'(nack), 32'd0);
    send_byte(d0, nack);
    expect_eq("data0_ack", 32'(nack), 32'd0);
    send_byte(d1, nack);
    expect_eq("data1_ack", 32'(nack), 32'd0);
    send_stop();
    wait_clk(4);
    expect_eq("start_pulses", 32'(n_start - s0), 32'd1);
    expect_eq("stop_pulses", 32'(n_stop - p0), 32'd1);
    expect_eq("addr_pulses", 32'(n_addr - a0), 32'd1);
    expect_eq("bus_addr", 32'(bus_addr_o), 32'({own_addr_i, 1'b0}));
    expect_eq("rx_writes", 32'(n_rx - x0), 32'd2);
    expect_eq("rx_byte0", 32'(rx_log[x0[5:0]]), 32'(d0));
    expect_eq("rx_byte1", 32'(rx_log[6'(x0 + 1)]), 32'(d1));
    expect_eq("flush_pulses", 32'(n_flush - f0), 32'd1);
    end_test();
endtask

task automatic run_standby_reject();
    logic [7:0] a;
    logic       nack;
    int         a0;
    int         x0;
    int         f0;
    begin_test("standby_reject");
    a = {own_addr_i ^ 7'h01, 1'b0};
    a0 = n_addr;
    x0 = n_rx;
    f0 = n_flush;
    send_start();
    send_byte(a, nack);
    expect_eq("mismatch_nack", 32'(nack), 32'd1);
    send_byte(8'(lcg_next() >> 16), nack);
    send_stop();
    wait_clk(4);
    expect_eq("mismatch_addr", 32'(bus_addr_o), 32'(a));
    rx_wready_i <= 1'b0;
    send_start();
    send_byte({own_addr_i, 1'b0}, nack);
    expect_eq("match_ack", 32'(nack), 32'd0);
    send_byte(8'(lcg_next() >> 16), nack);
    expect_eq("full_nack", 32'(nack), 32'd1);
    send_stop();
    wait_clk(4);
    rx_wready_i <= 1'b1;
    expect_eq("addr_pulses", 32'(n_addr - a0), 32'd2);
    expect_eq("rx_writes", 32'(n_rx - x0), 32'd0);
    expect_eq("flush_pulses", 32'(n_flush - f0), 32'd0);
    end_test();
endtask

task automatic run_role_select();
    cmd_t c;
    begin_test("role_select");
    c.dev_addr = 7'(lcg_next() >> 9);
    c.data = 8'(lcg_next() >> 16);
    role_chk <= 1'b1;
    issue_cmd(c);
    wait_resp();
    // Nobody on the bus answers
    expect_eq("resp", 32'(resp_wdata_o), 32'({c.dev_addr, 2'b10}));
    @(posedge clk_i);
    role_chk <= 1'b0;
    @(posedge clk_i);
    role_i <= 1'b0;
    end_test();
endtask

`endif

//--- tb_controller.sv
`timescale 1ns/1ps
// Testbench for the two-role bus controller
// Wired-AND bus model, event monitor and checking assertions;
// test sequences come from the included task file
module tb_controller;
    import controller_pkg::*;

    localparam int TbQuarter = 8;
    localparam int CycleLimit = 20000;

    logic        clk_i;
    logic        reset_i;
    logic        role_i;
    logic        active_en_i;
    logic        standby_en_i;
    logic [15:0] t_quarter_i;
    logic [6:0]  own_addr_i;
    logic        scl_i;
    logic        sda_i;
    logic        scl_o;
    logic        sda_o;
    logic        sel_od_pp_o;
    logic        cmd_rvalid_i;
    logic        cmd_rready_o;
    cmd_t        cmd_rdata_i;
    logic        resp_wvalid_o;
    logic        resp_wready_i;
    resp_t       resp_wdata_o;
    logic        rx_wvalid_o;
    logic        rx_wready_i;
    logic [7:0]  rx_wdata_o;
    logic        rx_wflush_o;
    logic        bus_start_o;
    logic        bus_stop_o;
    logic [7:0]  bus_addr_o;
    logic        bus_addr_valid_o;
    logic        idle_o;

    // Bus side driven by the testbench, 1 means released
    logic tb_scl;
    logic tb_sda;

    assign scl_i = scl_o & tb_scl;
    assign sda_i = sda_o & tb_sda;

    // Event counters, read as differences around each test
    int         scl_rises = 0;
    int         n_start = 0;
    int         n_stop = 0;
    int         n_addr = 0;
    int         n_rx = 0;
    int         n_flush = 0;
    logic [7:0] rx_log [0:63];
    logic       scl_prev = 1'b1;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    logic        hold_chk = 1'b0;
    logic        role_chk = 1'b0;
    resp_t       held_resp;
    logic [31:0] rng_state = 32'hb4c50888;

    controller controller_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        scl_prev <= scl_i;
        if (scl_i && !scl_prev) scl_rises <= scl_rises + 1;
        if (bus_start_o) n_start <= n_start + 1;
        if (bus_stop_o) n_stop <= n_stop + 1;
        if (bus_addr_valid_o) n_addr <= n_addr + 1;
        if (rx_wflush_o) n_flush <= n_flush + 1;
        if (rx_wvalid_o) begin
            rx_log[n_rx[5:0]] <= rx_wdata_o;
            n_rx <= n_rx + 1;
        end
    end

    // Held response must not change and no command may be taken
    assert property (@(posedge clk_i)
        hold_chk |-> (resp_wvalid_o && !cmd_rready_o && resp_wdata_o == held_resp))
    else begin
        errors++;
        $display("ERR active_addr_nack expected valid=1 ready=0 %h actual valid=%b ready=%b %h",
                 held_resp, resp_wvalid_o, cmd_rready_o, resp_wdata_o);
    end

    // Unselected active controller must not reach the SCL pad
    assert property (@(posedge clk_i) role_chk |-> scl_o)
    else begin
        errors++;
        $display("ERR role_select expected scl_o=1 actual scl_o=%b", scl_o);
    end

    always @(posedge clk_i) begin
        if (cycles >= CycleLimit) begin
            $display("Run stopped: cycle limit reached before the tests finished");
            $display("FAIL: see errors above");
            $finish;
        end
    end

    `include "tb_controller_tasks.svh"

    initial begin
        reset_i       = 1'b1;
        role_i        = 1'b0;
        active_en_i   = 1'b1;
        standby_en_i  = 1'b1;
        t_quarter_i   = 16'd3;
        own_addr_i    = 7'h00;
        cmd_rvalid_i  = 1'b0;
        cmd_rdata_i   = '0;
        resp_wready_i = 1'b1;
        rx_wready_i   = 1'b1;
        tb_scl        = 1'b1;
        tb_sda        = 1'b1;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        own_addr_i <= 7'(lcg_next() >> 9);

        run_reset_state();
        run_active_ack();
        run_active_nack();
        run_standby_rx();
        run_standby_reject();
        run_role_select();

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- controller.sv
`timescale 1ns/1ps
// Top level of the two-role bus controller
// role_i picks which controller drives the pads; both always see the bus
module controller (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 role_i,
    input  logic                                 active_en_i,
    input  logic                                 standby_en_i,
    input  logic [15:0]                          t_quarter_i,
    input  logic [controller_pkg::AddrWidth-1:0] own_addr_i,

    // Pads
    input  logic                                 scl_i,
    input  logic                                 sda_i,
    output logic                                 scl_o,
    output logic                                 sda_o,
    output logic                                 sel_od_pp_o,

    // Command and response queues
    input  logic                                 cmd_rvalid_i,
    output logic                                 cmd_rready_o,
    input  controller_pkg::cmd_t                 cmd_rdata_i,
    output logic                                 resp_wvalid_o,
    input  logic                                 resp_wready_i,
    output controller_pkg::resp_t                resp_wdata_o,

    // RX data queue
    output logic                                 rx_wvalid_o,
    input  logic                                 rx_wready_i,
    output logic [controller_pkg::ByteWidth-1:0] rx_wdata_o,
    output logic                                 rx_wflush_o,

    // Bus conditions and received address with RnW
    output logic                                 bus_start_o,
    output logic                                 bus_stop_o,
    output logic [controller_pkg::ByteWidth-1:0] bus_addr_o,
    output logic                                 bus_addr_valid_o,

    output logic                                 idle_o
);
    import controller_pkg::*;

    pad_t pad_active;
    pad_t pad_standby;
    pad_t pad_sel;

    // 0 is active, 1 is standby
    assign pad_sel     = role_i ? pad_standby : pad_active;
    assign scl_o       = pad_sel.scl;
    assign sda_o       = pad_sel.sda;
    assign sel_od_pp_o = pad_sel.od_pp;

    controller_active xcontroller_active (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .en_i          (active_en_i),
        .t_quarter_i   (t_quarter_i),
        .scl_i         (scl_i),
        .sda_i         (sda_i),
        .pad_o         (pad_active),
        .cmd_rvalid_i  (cmd_rvalid_i),
        .cmd_rready_o  (cmd_rready_o),
        .cmd_rdata_i   (cmd_rdata_i),
        .resp_wvalid_o (resp_wvalid_o),
        .resp_wready_i (resp_wready_i),
        .resp_wdata_o  (resp_wdata_o),
        .idle_o        (idle_o)
    );

    controller_standby xcontroller_standby (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .en_i             (standby_en_i),
        .own_addr_i       (own_addr_i),
        .scl_i            (scl_i),
        .sda_i            (sda_i),
        .pad_o            (pad_standby),
        .rx_wvalid_o      (rx_wvalid_o),
        .rx_wready_i      (rx_wready_i),
        .rx_wdata_o       (rx_wdata_o),
        .rx_wflush_o      (rx_wflush_o),
        .bus_start_o      (bus_start_o),
        .bus_stop_o       (bus_stop_o),
        .bus_addr_o       (bus_addr_o),
        .bus_addr_valid_o (bus_addr_valid_o)
    );

endmodule

//--- controller_standby.sv
`timescale 1ns/1ps
// Bus target receiver
// Reports START, STOP and every address byte, ACKs its own write
// address and pushes accepted data bytes into the RX queue
module controller_standby (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 en_i,
    input  logic [controller_pkg::AddrWidth-1:0] own_addr_i,
    input  logic                                 scl_i,
    input  logic                                 sda_i,
    output controller_pkg::pad_t                 pad_o,
    output logic                                 rx_wvalid_o,
    input  logic                                 rx_wready_i,
    output logic [controller_pkg::ByteWidth-1:0] rx_wdata_o,
    output logic                                 rx_wflush_o,
    output logic                                 bus_start_o,
    output logic                                 bus_stop_o,
    output logic [controller_pkg::ByteWidth-1:0] bus_addr_o,
    output logic                                 bus_addr_valid_o
);
    import controller_pkg::*;

    bus_event_t           events;
    logic                 in_msg_q;
    logic                 first_q;
    logic                 match_q;
    logic                 ack_pend_q;
    logic                 ack_drive_q;
    logic                 wrote_q;
    logic [3:0]           bit_q;
    logic [ByteWidth-2:0] shift_q;
    logic [ByteWidth-1:0] rx_byte;
    logic                 bit_rise;
    logic                 byte_done;
    logic                 rx_take;

    bus_monitor xbus_monitor (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .scl_i    (scl_i),
        .sda_i    (sda_i),
        .events_o (events)
    );

    assign rx_byte   = {shift_q, events.sda};
    assign bit_rise  = en_i && in_msg_q && events.scl_rise;
    assign byte_done = bit_rise && (bit_q == 4'd7);
    assign rx_take   = match_q && rx_wready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            in_msg_q         <= 1'b0;
            first_q          <= 1'b0;
            match_q          <= 1'b0;
            ack_pend_q       <= 1'b0;
            ack_drive_q      <= 1'b0;
            wrote_q          <= 1'b0;
            bit_q            <= '0;
            bus_start_o      <= 1'b0;
            bus_stop_o       <= 1'b0;
            bus_addr_valid_o <= 1'b0;
            rx_wvalid_o      <= 1'b0;
            rx_wflush_o      <= 1'b0;
        end else begin
            bus_start_o      <= en_i && events.start;
            bus_stop_o       <= en_i && events.stop;
            bus_addr_valid_o <= 1'b0;
            rx_wvalid_o      <= 1'b0;
            rx_wflush_o      <= 1'b0;

            if (!en_i) begin
                in_msg_q    <= 1'b0;
                ack_drive_q <= 1'b0;
            end else if (events.start) begin
                // Also covers repeated START
                in_msg_q    <= 1'b1;
                first_q     <= 1'b1;
                bit_q       <= '0;
                ack_pend_q  <= 1'b0;
                ack_drive_q <= 1'b0;
            end else if (events.stop) begin
                in_msg_q    <= 1'b0;
                ack_drive_q <= 1'b0;
                rx_wflush_o <= wrote_q;
                wrote_q     <= 1'b0;
            end else if (in_msg_q) begin
                // Bits 0..7 are the byte, bit 8 is the ACK slot
                if (bit_rise) begin
                    bit_q <= (bit_q == 4'd8) ? 4'd0 : bit_q + 4'd1;
                end
                if (byte_done) begin
                    first_q <= 1'b0;
                    if (first_q) begin
                        // Writes only, reads are not supported
                        bus_addr_valid_o <= 1'b1;
                        match_q    <= (rx_byte[ByteWidth-1:1] == own_addr_i) && !rx_byte[0];
                        ack_pend_q <= (rx_byte[ByteWidth-1:1] == own_addr_i) && !rx_byte[0];
                    end else begin
                        ack_pend_q  <= rx_take;
                        rx_wvalid_o <= rx_take;
                        wrote_q     <= wrote_q || rx_take;
                    end
                end
                // Drive on the fall after bit 7, release on the next fall
                if (events.scl_fall) begin
                    ack_drive_q <= ack_pend_q && (bit_q == 4'd8);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bit_rise) begin
            shift_q <= rx_byte[ByteWidth-2:0];
        end
        if (byte_done) begin
            if (first_q) begin
                bus_addr_o <= rx_byte;
            end else begin
                rx_wdata_o <= rx_byte;
            end
        end
    end

    // Target never touches SCL
    always_comb begin
        pad_o     = PadReleased;
        pad_o.sda = !ack_drive_q;
    end

endmodule

//--- controller_active.sv
`timescale 1ns/1ps
// Bus master for single-byte writes
// Takes one command word, sends START, address+W, data and STOP,
// then holds a response word until the response queue takes it
module controller_active (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  en_i,
    input  logic [15:0]           t_quarter_i,
    input  logic                  scl_i,
    input  logic                  sda_i,
    output controller_pkg::pad_t  pad_o,
    input  logic                  cmd_rvalid_i,
    output logic                  cmd_rready_o,
    input  controller_pkg::cmd_t  cmd_rdata_i,
    output logic                  resp_wvalid_o,
    input  logic                  resp_wready_i,
    output controller_pkg::resp_t resp_wdata_o,
    output logic                  idle_o
);
    import controller_pkg::*;

    typedef enum logic [2:0] {
        StIdle,
        StStart,
        StAddr,
        StAddrAck,
        StData,
        StDataAck,
        StStop,
        StResp
    } state_e;

    state_e               state_q;
    logic [15:0]          qcnt_q;
    logic [1:0]           quarter_q;
    logic [2:0]           bit_q;
    logic [ByteWidth-1:0] shift_q;
    cmd_t                 cmd_q;
    logic                 addr_nack_q;
    logic                 data_nack_q;
    logic                 tick;
    logic                 scl_high;
    bus_event_t           events;

    // Readback of the wired bus for the ACK slots
    bus_monitor xbus_monitor (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .scl_i    (scl_i),
        .sda_i    (sda_i),
        .events_o (events)
    );

    assign tick         = (qcnt_q == t_quarter_i);
    assign scl_high     = (quarter_q == 2'd1) || (quarter_q == 2'd2);
    assign cmd_rready_o = (state_q == StIdle) && en_i && cmd_rvalid_i;
    assign idle_o       = (state_q == StIdle);
    assign resp_wvalid_o = (state_q == StResp);
    assign resp_wdata_o = '{
        dev_addr:  cmd_q.dev_addr,
        addr_nack: addr_nack_q,
        data_nack: data_nack_q
    };

    // Quarter-bit timer, t_quarter_i+1 clocks per quarter
    always_ff @(posedge clk_i) begin
        if (reset_i || state_q == StIdle || state_q == StResp || tick) begin
            qcnt_q <= '0;
        end else begin
            qcnt_q <= qcnt_q + 16'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= StIdle;
            quarter_q   <= '0;
            bit_q       <= '0;
            addr_nack_q <= 1'b0;
            data_nack_q <= 1'b0;
        end else begin
            case (state_q)
                StIdle: begin
                    if (cmd_rready_o) begin
                        state_q     <= StStart;
                        quarter_q   <= '0;
                        addr_nack_q <= 1'b0;
                        data_nack_q <= 1'b0;
                    end
                end
                StResp: begin
                    if (resp_wready_i) begin
                        state_q <= StIdle;
                    end
                end
                default: begin
                    if (tick) begin
                        quarter_q <= quarter_q + 2'd1;
                        case (state_q)
                            StStart: begin
                                if (quarter_q == 2'd1) begin
                                    quarter_q <= '0;
                                    bit_q     <= 3'd7;
                                    state_q   <= StAddr;
                                end
                            end
                            StAddr, StData: begin
                                if (quarter_q == 2'd3) begin
                                    if (bit_q == 3'd0) begin
                                        state_q <= (state_q == StAddr) ? StAddrAck : StDataAck;
                                    end else begin
                                        bit_q <= bit_q - 3'd1;
                                    end
                                end
                            end
                            StAddrAck: begin
                                // Middle of SCL high
                                if (quarter_q == 2'd1) begin
                                    addr_nack_q <= events.sda;
                                end
                                if (quarter_q == 2'd3) begin
                                    bit_q   <= 3'd7;
                                    state_q <= addr_nack_q ? StStop : StData;
                                end
                            end
                            StDataAck: begin
                                if (quarter_q == 2'd1) begin
                                    data_nack_q <= events.sda;
                                end
                                if (quarter_q == 2'd3) begin
                                    state_q <= StStop;
                                end
                            end
                            StStop: begin
                                if (quarter_q == 2'd1) begin
                                    quarter_q <= '0;
                                    state_q   <= StResp;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
            endcase
        end
    end

    // Command and shift payload
    always_ff @(posedge clk_i) begin
        if (cmd_rready_o) begin
            cmd_q   <= cmd_rdata_i;
            shift_q <= {cmd_rdata_i.dev_addr, 1'b0};
        end else if (tick && quarter_q == 2'd3) begin
            if (state_q == StAddrAck) begin
                shift_q <= cmd_q.data;
            end else if (state_q == StAddr || state_q == StData) begin
                shift_q <= {shift_q[ByteWidth-2:0], 1'b0};
            end
        end
    end

    // SDA set in quarter 0, SCL high in quarters 1 and 2
    always_comb begin
        pad_o = PadReleased;
        case (state_q)
            StStart: begin
                pad_o.scl = (quarter_q == 2'd0);
                pad_o.sda = 1'b0;
            end
            StAddr, StData: begin
                pad_o.scl = scl_high;
                pad_o.sda = shift_q[ByteWidth-1];
            end
            StAddrAck, StDataAck: begin
                pad_o.scl = scl_high;
            end
            StStop: begin
                // SDA released on leaving, which is the STOP edge
                pad_o.scl = (quarter_q == 2'd1);
                pad_o.sda = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

//--- bus_monitor.sv
`timescale 1ns/1ps
// Pad line synchronizer and bus condition detector
// Two flops per line, then a registered compare stage, so a pin
// change shows up as an event three clocks later
module bus_monitor (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       scl_i,
    input  logic                       sda_i,
    output controller_pkg::bus_event_t events_o
);

    logic [1:0] scl_sync_q;
    logic [1:0] sda_sync_q;
    logic       scl_now;
    logic       sda_now;

    assign scl_now = scl_sync_q[1];
    assign sda_now = sda_sync_q[1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Idle bus has both lines pulled up
            scl_sync_q <= 2'b11;
            sda_sync_q <= 2'b11;
            events_o   <= '{scl: 1'b1, sda: 1'b1, default: 1'b0};
        end else begin
            scl_sync_q <= {scl_sync_q[0], scl_i};
            sda_sync_q <= {sda_sync_q[0], sda_i};

            // Previous levels live in the event register itself
            events_o.scl <= scl_now;
            events_o.sda <= sda_now;

            // SDA moving while SCL stays high
            events_o.start <= events_o.scl && scl_now && events_o.sda && !sda_now;
            events_o.stop  <= events_o.scl && scl_now && !events_o.sda && sda_now;

            events_o.scl_rise <= !events_o.scl && scl_now;
            events_o.scl_fall <= events_o.scl && !scl_now;
        end
    end

endmodule

//--- controller_pkg.sv
// Shared types and constants for the two-role bus controller
// Import into a module body; use scoped names in module headers
package controller_pkg;

    // 7-bit addressing, one byte per data phase
    localparam int AddrWidth = 7;
    localparam int ByteWidth = 8;

    // Host command word, always a single-byte write
    typedef struct packed {
        logic [AddrWidth-1:0] dev_addr;
        logic [ByteWidth-1:0] data;
    } cmd_t;

    // Response word pushed after STOP
    typedef struct packed {
        logic [AddrWidth-1:0] dev_addr;
        logic                 addr_nack;
        logic                 data_nack;
    } resp_t;

    // Synchronized levels plus one-cycle condition pulses
    typedef struct packed {
        logic scl;
        logic sda;
        logic start;
        logic stop;
        logic scl_rise;
        logic scl_fall;
    } bus_event_t;

    // Pad drive of one controller, 1 on scl/sda means released
    typedef struct packed {
        logic scl;
        logic sda;
        logic od_pp;
    } pad_t;

    localparam pad_t PadReleased = '{scl: 1'b1, sda: 1'b1, od_pp: 1'b0};

endpackage
